// File: logic/alut_macros.svh
`ifndef ALUT_MACROS_SVH
`define ALUT_MACROS_SVH

// table geometry
`define ALUT_DEPTH    256   // entries, direct mapped
`define ALUT_IDX_W    8     // table index width

// bridge ports
`define ALUT_PORT_W   2     // four ports

// frame counter used as time base
`define ALUT_STAMP_W  32

// one table word
// valid + port + stamp + mac
`define ALUT_DW       83

`endif

// File: logic/alut_pkg.sv
`default_nettype none

`include "alut_macros.svh"

package alut_pkg;

   // one table word as stored in alut_mem
   typedef struct packed {
      logic                     valid;
      logic [`ALUT_PORT_W-1:0]  port;   // port the mac was learned on
      logic [`ALUT_STAMP_W-1:0] stamp;  // frame count at learn time
      logic [47:0]              mac;
   } alut_entry_t;

   typedef enum logic [1:0] {
      FRAME = 2'd0,  // lookup dst, learn src
      SWEEP = 2'd1,  // age out stale entries
      NOP   = 2'd2
   } alut_op_t;

   // command payload, meaning depends on op
   typedef union packed {
      struct packed {
         logic [47:0]             dst_mac;
         logic [47:0]             src_mac;
         logic [`ALUT_PORT_W-1:0] src_port;
      } frame_f;
      struct packed {
         logic [`ALUT_STAMP_W-1:0]                  age_limit;
         logic [2*48+`ALUT_PORT_W-`ALUT_STAMP_W-1:0] pad;  // unused
      } sweep_f;
   } alut_cmd_u;

   typedef struct packed {
      alut_op_t  op;
      alut_cmd_u body;
   } alut_cmd_t;

   // decoded command, indices already folded
   typedef struct packed {
      alut_op_t                 op;
      logic [`ALUT_IDX_W-1:0]   dst_idx;
      logic [`ALUT_IDX_W-1:0]   src_idx;
      logic [47:0]              dst_mac;
      logic [47:0]              src_mac;
      logic [`ALUT_PORT_W-1:0]  src_port;
      logic [`ALUT_STAMP_W-1:0] age_limit;
   } alut_dec_t;

   typedef struct packed {
      logic                    hit;
      logic [`ALUT_PORT_W-1:0] fwd_port;  // zero on a miss
      logic                    flood;
      logic                    filter;    // dst sits on the src port, drop
   } alut_res_t;

endpackage

`default_nettype wire

// File: logic/alut_mem.sv
`default_nettype none

`include "alut_macros.svh"

module alut_mem
(
   input  logic                   pclk2,
   // address checker port
   input  logic [`ALUT_IDX_W-1:0] add_idx,
   input  logic                   add_we,     // high writes, low reads
   input  alut_pkg::alut_entry_t  add_wdata,
   output alut_pkg::alut_entry_t  add_rdata,
   // age checker port
   input  logic [`ALUT_IDX_W-1:0] age_idx,
   input  logic                   age_we,
   input  alut_pkg::alut_entry_t  age_wdata,
   output alut_pkg::alut_entry_t  age_rdata
);

   logic [`ALUT_DW-1:0] mem_array [`ALUT_DEPTH];  // cleared by the ager

   // ----------------------------------------------------------
   // both ports, each reads or writes every edge
   // ----------------------------------------------------------
   always_ff @(posedge pclk2)
   begin
      if (add_we)
         mem_array[add_idx] <= add_wdata;
      else
         add_rdata <= mem_array[add_idx];  // data valid next cycle

      if (age_we)
         mem_array[age_idx] <= age_wdata;
      else
         age_rdata <= mem_array[age_idx];
   end

   // execute and ager must never collide on one entry
   a_no_dual_write: assert property (@(posedge pclk2)
      !(add_we && age_we && (add_idx == age_idx)))
      else $error("alut_mem: both ports write index %0d", add_idx);

endmodule

`default_nettype wire

// File: logic/alut_decode.sv
`default_nettype none

`include "alut_macros.svh"

module alut_decode
(
   input  logic                pclk2,
   input  logic                arst_n,
   input  logic                cmd_valid,  // single cycle strobe
   input  alut_pkg::alut_cmd_t cmd,
   input  logic                busy,
   output logic                dec_valid,
   output alut_pkg::alut_dec_t dec
);

   import alut_pkg::*;

   alut_dec_t dec_nxt;
   logic      cmd_known;

   // xor of the six mac bytes gives the table index
   function automatic logic [`ALUT_IDX_W-1:0] mac_fold(input logic [47:0] mac);
      logic [7:0] acc;
      acc = '0;
      for (int b = 0; b < 6; b++)
      begin
         acc ^= mac[8*b +: 8];
      end
      return acc;
   endfunction

   // ----------------------------------------------------------
   // pick the union view by op
   // ----------------------------------------------------------
   always_comb
   begin
      dec_nxt    = '0;
      dec_nxt.op = cmd.op;
      case (cmd.op)
         FRAME:
         begin
            dec_nxt.dst_mac  = cmd.body.frame_f.dst_mac;
            dec_nxt.src_mac  = cmd.body.frame_f.src_mac;
            dec_nxt.src_port = cmd.body.frame_f.src_port;
            dec_nxt.dst_idx  = mac_fold(cmd.body.frame_f.dst_mac);
            dec_nxt.src_idx  = mac_fold(cmd.body.frame_f.src_mac);
         end
         SWEEP:
            dec_nxt.age_limit = cmd.body.sweep_f.age_limit;
         default:
            dec_nxt.op = NOP;  // unknown codes fold to nop
      endcase
   end

   assign cmd_known = (cmd.op == FRAME) || (cmd.op == SWEEP);  // nop is dropped here

   always_ff @(posedge pclk2 or negedge arst_n)
   begin
      if (!arst_n)
         dec_valid <= 1'b0;
      else
         dec_valid <= cmd_valid && cmd_known;
   end

   always_ff @(posedge pclk2)
   begin
      if (cmd_valid)
         dec <= dec_nxt;
   end

   // environment must hold off while a command or the clear is running
   a_no_cmd_while_busy: assert property (@(posedge pclk2) disable iff (!arst_n)
      cmd_valid |-> !busy)
      else $error("alut_decode: command issued while busy");

endmodule

`default_nettype wire

// File: logic/alut_execute.sv
`default_nettype none

`include "alut_macros.svh"

module alut_execute
(
   input  logic                     pclk2,
   input  logic                     arst_n,
   input  logic                     dec_valid,
   input  alut_pkg::alut_dec_t      dec,
   input  logic                     ager_busy,
   // address port of the table
   output logic [`ALUT_IDX_W-1:0]   add_idx,
   output logic                     add_we,
   output alut_pkg::alut_entry_t    add_wdata,
   // to result stage, valid with the read data
   output logic                     lookup_valid,
   output logic [47:0]              lookup_mac,
   output logic [`ALUT_PORT_W-1:0]  lookup_port,
   // to ager
   output logic                     sweep_start,
   output logic [`ALUT_STAMP_W-1:0] age_limit,
   output logic [`ALUT_STAMP_W-1:0] now_stamp,
   output logic                     busy
);

   import alut_pkg::*;

   typedef enum logic [1:0] {
      EX_IDLE,   // read issued from here when a frame decodes
      EX_LEARN,  // read data back, learn write on the add port
      EX_DONE    // result registered, last busy cycle
   } ex_state_t;

   ex_state_t                state;
   logic [`ALUT_STAMP_W-1:0] frame_cnt;  // time base, counts frames
   logic                     frame_go;
   logic                     learning;
   // captured frame fields
   logic [`ALUT_IDX_W-1:0]   src_idx_q;
   logic [47:0]              src_mac_q;
   logic [47:0]              dst_mac_q;
   logic [`ALUT_PORT_W-1:0]  src_port_q;

   assign frame_go    = dec_valid && (dec.op == FRAME);
   assign sweep_start = dec_valid && (dec.op == SWEEP);  // one cycle pulse
   assign age_limit   = dec.age_limit;                    // ager latches it
   assign now_stamp   = frame_cnt;
   assign learning    = (state == EX_LEARN);

   // ----------------------------------------------------------
   // add port, lookup first then learn
   // ----------------------------------------------------------
   assign add_we  = learning;
   assign add_idx = learning ? src_idx_q : dec.dst_idx;

   always_comb
   begin
      add_wdata       = '0;
      add_wdata.valid = 1'b1;
      add_wdata.port  = src_port_q;
      add_wdata.stamp = frame_cnt;  // count before this frame's increment
      add_wdata.mac   = src_mac_q;
   end

   assign lookup_valid = learning;
   assign lookup_mac   = dst_mac_q;
   assign lookup_port  = src_port_q;

   assign busy = dec_valid || (state != EX_IDLE) || ager_busy;

   always_ff @(posedge pclk2 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= EX_IDLE;
         frame_cnt <= '0;
      end
      else
      begin
         case (state)
            EX_IDLE:
               if (frame_go)
                  state <= EX_LEARN;
            EX_LEARN:
            begin
               state     <= EX_DONE;
               frame_cnt <= frame_cnt + 1'b1;  // wraps, ager diff is modular
            end
            default:
               state <= EX_IDLE;
         endcase
      end
   end

   always_ff @(posedge pclk2)
   begin
      if (frame_go)
      begin
         src_idx_q  <= dec.src_idx;
         src_mac_q  <= dec.src_mac;
         dst_mac_q  <= dec.dst_mac;
         src_port_q <= dec.src_port;
      end
   end

endmodule

`default_nettype wire

// File: logic/alut_ager.sv
`default_nettype none

`include "alut_macros.svh"

module alut_ager
(
   input  logic                     pclk2,
   input  logic                     arst_n,
   input  logic                     sweep_start,
   input  logic [`ALUT_STAMP_W-1:0] age_limit,
   input  logic [`ALUT_STAMP_W-1:0] now_stamp,  // held by execute during a sweep
   // age port of the table
   output logic [`ALUT_IDX_W-1:0]   age_idx,
   output logic                     age_we,
   output alut_pkg::alut_entry_t    age_wdata,
   input  alut_pkg::alut_entry_t    age_rdata,
   output logic                     ager_busy,
   output logic                     sweep_done,
   output logic [`ALUT_IDX_W:0]     sweep_count  // entries dropped by last sweep
);

   import alut_pkg::*;

   typedef enum logic [1:0] {
      AG_CLEAR,  // zero fill after reset
      AG_IDLE,
      AG_SWEEP   // read, then maybe write, per index
   } ag_state_t;

   ag_state_t                state;
   logic [`ALUT_IDX_W-1:0]   idx;
   logic                     wr_slot;   // write cycle of the pair, also clear enable
   logic                     last_idx;
   logic [`ALUT_STAMP_W-1:0] limit_q;
   logic [`ALUT_STAMP_W-1:0] age_diff;
   logic                     stale;
   alut_entry_t              aged;

   assign last_idx  = (int'(idx) == `ALUT_DEPTH - 1);
   assign ager_busy = (state != AG_IDLE);
   assign age_idx   = idx;

   // ----------------------------------------------------------
   // staleness, read data belongs to idx in the write slot
   // ----------------------------------------------------------
   assign age_diff = now_stamp - age_rdata.stamp;  // modulo 2^32
   assign stale    = age_rdata.valid && (age_diff > limit_q);

   always_comb
   begin
      aged       = age_rdata;
      aged.valid = 1'b0;  // keep the rest of the word
   end

   always_comb
   begin
      if (state == AG_CLEAR)
         age_wdata = '0;
      else
         age_wdata = aged;
   end

   assign age_we = wr_slot && ((state == AG_CLEAR) || ((state == AG_SWEEP) && stale));

   always_ff @(posedge pclk2 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state       <= AG_CLEAR;
         idx         <= '0;
         wr_slot     <= 1'b0;
         sweep_done  <= 1'b0;
         sweep_count <= '0;
      end
      else
      begin
         sweep_done <= 1'b0;
         case (state)
            AG_CLEAR:
            begin
               wr_slot <= 1'b1;  // one write per cycle
               if (wr_slot)
               begin
                  idx <= idx + 1'b1;
                  if (last_idx)
                  begin
                     state   <= AG_IDLE;  // no done pulse for the clear
                     wr_slot <= 1'b0;
                  end
               end
            end
            AG_IDLE:
               if (sweep_start)
               begin
                  state       <= AG_SWEEP;
                  idx         <= '0;
                  sweep_count <= '0;
               end
            AG_SWEEP:
            begin
               wr_slot <= !wr_slot;
               if (wr_slot)
               begin
                  idx <= idx + 1'b1;
                  if (stale)
                     sweep_count <= sweep_count + 1'b1;
                  if (last_idx)
                  begin
                     state      <= AG_IDLE;
                     sweep_done <= 1'b1;  // count final in the same cycle
                  end
               end
            end
            default:
               state <= AG_IDLE;
         endcase
      end
   end

   always_ff @(posedge pclk2)
   begin
      if (sweep_start)
         limit_q <= age_limit;
   end

   // decode blocks commands while busy, so a sweep never lands mid-walk
   a_start_when_idle: assert property (@(posedge pclk2) disable iff (!arst_n)
      sweep_start |-> !ager_busy)
      else $error("alut_ager: sweep_start while ager busy");

endmodule

`default_nettype wire

// File: logic/alut_result.sv
`default_nettype none

`include "alut_macros.svh"

module alut_result
(
   input  logic                    pclk2,
   input  logic                    arst_n,
   input  logic                    lookup_valid,  // add_rdata holds the dst entry
   input  logic [47:0]             lookup_mac,
   input  logic [`ALUT_PORT_W-1:0] lookup_port,   // port the frame came in on
   input  alut_pkg::alut_entry_t   add_rdata,
   output logic                    res_valid,
   output alut_pkg::alut_res_t     res
);

   import alut_pkg::*;

   alut_res_t res_nxt;
   logic      mac_eq;

   // ----------------------------------------------------------
   // forwarding decision
   // ----------------------------------------------------------
   assign mac_eq = (add_rdata.mac == lookup_mac);

   always_comb
   begin
      res_nxt     = '0;
      res_nxt.hit = add_rdata.valid && mac_eq;  // stale index owner is a miss
      if (res_nxt.hit)
         res_nxt.fwd_port = add_rdata.port;
      res_nxt.flood  = !res_nxt.hit;
      res_nxt.filter = res_nxt.hit && (add_rdata.port == lookup_port);
   end

   always_ff @(posedge pclk2 or negedge arst_n)
   begin
      if (!arst_n)
         res_valid <= 1'b0;
      else
         res_valid <= lookup_valid;  // single cycle pulse
   end

   always_ff @(posedge pclk2)
   begin
      if (lookup_valid)
         res <= res_nxt;
   end

endmodule

`default_nettype wire

// File: logic/alut_top.sv
`default_nettype none

`include "alut_macros.svh"

module alut_top
(
   input  logic                pclk2,
   input  logic                arst_n,
   input  logic                cmd_valid,
   input  alut_pkg::alut_cmd_t cmd,
   output logic                busy,
   output logic                res_valid,
   output alut_pkg::alut_res_t res,
   output logic                sweep_done,
   output logic [`ALUT_IDX_W:0] sweep_count
);

   import alut_pkg::*;

   // decode to execute
   logic                     dec_valid;
   alut_dec_t                dec;

   // add port
   logic [`ALUT_IDX_W-1:0]   add_idx;
   logic                     add_we;
   alut_entry_t              add_wdata;
   alut_entry_t              add_rdata;

   // age port
   logic [`ALUT_IDX_W-1:0]   age_idx;
   logic                     age_we;
   alut_entry_t              age_wdata;
   alut_entry_t              age_rdata;

   logic                     lookup_valid;
   logic [47:0]              lookup_mac;
   logic [`ALUT_PORT_W-1:0]  lookup_port;
   logic                     sweep_start;
   logic [`ALUT_STAMP_W-1:0] age_limit;
   logic [`ALUT_STAMP_W-1:0] now_stamp;
   logic                     ager_busy;

   // ----------------------------------------------------------
   // pipeline
   // ----------------------------------------------------------
   alut_decode u_decode (
      .pclk2     (pclk2),
      .arst_n    (arst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .busy      (busy),
      .dec_valid (dec_valid),
      .dec       (dec)
   );

   alut_execute u_execute (
      .pclk2        (pclk2),
      .arst_n       (arst_n),
      .dec_valid    (dec_valid),
      .dec          (dec),
      .ager_busy    (ager_busy),
      .add_idx      (add_idx),
      .add_we       (add_we),
      .add_wdata    (add_wdata),
      .lookup_valid (lookup_valid),
      .lookup_mac   (lookup_mac),
      .lookup_port  (lookup_port),
      .sweep_start  (sweep_start),
      .age_limit    (age_limit),
      .now_stamp    (now_stamp),
      .busy         (busy)
   );

   alut_result u_result (
      .pclk2        (pclk2),
      .arst_n       (arst_n),
      .lookup_valid (lookup_valid),
      .lookup_mac   (lookup_mac),
      .lookup_port  (lookup_port),
      .add_rdata    (add_rdata),
      .res_valid    (res_valid),
      .res          (res)
   );

   // ----------------------------------------------------------
   // aging and table
   // ----------------------------------------------------------
   alut_ager u_ager (
      .pclk2       (pclk2),
      .arst_n      (arst_n),
      .sweep_start (sweep_start),
      .age_limit   (age_limit),
      .now_stamp   (now_stamp),
      .age_idx     (age_idx),
      .age_we      (age_we),
      .age_wdata   (age_wdata),
      .age_rdata   (age_rdata),
      .ager_busy   (ager_busy),
      .sweep_done  (sweep_done),
      .sweep_count (sweep_count)
   );

   alut_mem u_mem (
      .pclk2     (pclk2),
      .add_idx   (add_idx),
      .add_we    (add_we),
      .add_wdata (add_wdata),
      .add_rdata (add_rdata),
      .age_idx   (age_idx),
      .age_we    (age_we),
      .age_wdata (age_wdata),
      .age_rdata (age_rdata)
   );

endmodule

`default_nettype wire

// File: bench/alut_tb.sv
`default_nettype none

`include "alut_macros.svh"

module alut_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import alut_pkg::*;

   localparam int RESET_CYCLES   = 10;
   localparam int CYCLES_PER_VEC = 600;  // a sweep walk is about 515
   localparam int CLEAR_CYCLES   = 300;  // zero fill after reset
   localparam int FRAME_LATENCY  = 3;

   // one line of the vectors file
   typedef struct packed {
      alut_op_t                 op;
      logic [47:0]              dst_mac;
      logic [47:0]              src_mac;
      logic [`ALUT_PORT_W-1:0]  src_port;
      logic [`ALUT_STAMP_W-1:0] age_limit;
      alut_res_t                exp_res;    // frame lines only
      logic [`ALUT_IDX_W:0]     exp_count;  // sweep lines only
   } vec_t;

   logic                 pclk2;
   logic                 arst_n;
   logic                 cmd_valid;
   alut_cmd_t            cmd;
   logic                 busy;
   logic                 res_valid;
   alut_res_t            res;
   logic                 sweep_done;
   logic [`ALUT_IDX_W:0] sweep_count;

   vec_t vecs[$];
   int   checks;
   int   value_errors;
   int   proto_errors;   // missing or stuck strobes, file trouble, timeout
   int   cycles;
   int   cycle_limit;

   alut_top uut (
      .pclk2       (pclk2),
      .arst_n      (arst_n),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .busy        (busy),
      .res_valid   (res_valid),
      .res         (res),
      .sweep_done  (sweep_done),
      .sweep_count (sweep_count)
   );

   always
   begin
      pclk2 = 1'b0;
      #50;
      pclk2 = 1'b1;
      #50;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic load_vectors();
      int          fd;
      int          rc;
      string       line;
      vec_t        v;
      logic [1:0]  op;
      logic [47:0] dst;
      logic [47:0] src;
      logic [1:0]  port;
      logic [31:0] limit;
      logic        hit;
      logic [1:0]  fwd;
      logic        flood;
      logic        filt;
      logic [8:0]  cnt;
      fd = $fopen("bench/alut_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("could not open bench/alut_vectors.txt");
         proto_errors++;
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         rc   = $fgets(line, fd);
         if (rc > 0 && line.len() > 0 && line[0] != "#" && line[0] != "\n")
         begin
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                         op, dst, src, port, limit, hit, fwd, flood, filt, cnt);
            if (rc == 10)
            begin
               v                  = '0;
               v.op               = alut_op_t'(op);
               v.dst_mac          = dst;
               v.src_mac          = src;
               v.src_port         = port;
               v.age_limit        = limit;
               v.exp_res.hit      = hit;
               v.exp_res.fwd_port = fwd;
               v.exp_res.flood    = flood;
               v.exp_res.filter   = filt;
               v.exp_count        = cnt;
               vecs.push_back(v);
            end
            else
            begin
               $display("vector file line could not be read: %s", line);
               proto_errors++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_value(input int i, input string what,
                              input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("ERROR %0d ns: vector %0d %s is %0h, expected %0h", $time, i, what, got, exp);
      end
   endtask

   // single cycle strobe that returns on the edge dropping it
   task automatic drive_cmd(input alut_cmd_t c);
      @(posedge pclk2);
      cmd_valid <= 1'b1;
      cmd       <= c;
      @(posedge pclk2);
      cmd_valid <= 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge pclk2);
      while (busy)
         @(negedge pclk2);
   endtask

   task automatic run_frame(input int i);
      alut_cmd_t c;
      vec_t      v;
      v                         = vecs[i];
      c                         = '0;
      c.op                      = FRAME;
      c.body.frame_f.dst_mac    = v.dst_mac;
      c.body.frame_f.src_mac    = v.src_mac;
      c.body.frame_f.src_port   = v.src_port;
      drive_cmd(c);
      // cycles 1 to 3, busy all along, result only in the last
      for (int k = 1; k <= FRAME_LATENCY; k++)
      begin
         @(negedge pclk2);  // res stable mid cycle
         check_value(i, "busy", busy, 1);
         if (k < FRAME_LATENCY && res_valid)
         begin
            $display("vector %0d: res_valid came %0d cycles early", i, FRAME_LATENCY - k);
            proto_errors++;
         end
      end
      if (!res_valid)
      begin
         $display("vector %0d: no res_valid %0d cycles after the frame", i, FRAME_LATENCY);
         proto_errors++;
      end
      else
      begin
         check_value(i, "hit", res.hit, v.exp_res.hit);
         check_value(i, "fwd_port", res.fwd_port, v.exp_res.fwd_port);
         check_value(i, "flood", res.flood, v.exp_res.flood);
         check_value(i, "filter", res.filter, v.exp_res.filter);
      end
      @(negedge pclk2);
      if (res_valid)
      begin
         $display("vector %0d: res_valid stayed high past one cycle", i);
         proto_errors++;
      end
      check_value(i, "busy", busy, 0);  // frame over
   endtask

   task automatic run_sweep(input int i);
      alut_cmd_t c;
      logic      seen;
      int        n;
      c                        = '0;
      c.op                     = SWEEP;
      c.body.sweep_f.age_limit = vecs[i].age_limit;
      seen                     = 1'b0;
      n                        = 0;
      drive_cmd(c);
      while (!seen && n < CYCLES_PER_VEC)
      begin
         @(negedge pclk2);
         seen = sweep_done;
         if (!seen)
            check_value(i, "busy", busy, 1);  // held through the walk
         n++;
      end
      if (!seen)
      begin
         $display("vector %0d: sweep_done never came", i);
         proto_errors++;
      end
      else
         check_value(i, "sweep_count", sweep_count, vecs[i].exp_count);
   endtask

   task automatic end_run();
      $display("checks %0d, value errors %0d, protocol errors %0d",
               checks, value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0 && checks > 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   // ------------------------------------------------------------
   // watchdog
   // ------------------------------------------------------------
   always @(posedge pclk2)
   begin
      cycles++;
      if (cycles > cycle_limit)
      begin
         $display("timeout, run still going after %0d cycles", cycles);
         proto_errors++;
         end_run();
      end
   end

   initial
   begin
      arst_n       = 1'b0;
      cmd_valid    = 1'b0;
      cmd          = '0;
      checks       = 0;
      value_errors = 0;
      proto_errors = 0;
      cycles       = 0;
      load_vectors();
      cycle_limit = vecs.size() * CYCLES_PER_VEC + CLEAR_CYCLES;
      repeat (RESET_CYCLES)
         @(posedge pclk2);
      arst_n <= 1'b1;
      @(negedge pclk2);
      checks++;
      if (busy !== 1'b1)
      begin
         value_errors++;
         $display("ERROR %0d ns: busy low right after reset, clear not running", $time);
      end
      wait_idle();  // table clear done
      foreach (vecs[i])
      begin
         if (vecs[i].op == SWEEP)
            run_sweep(i);
         else
            run_frame(i);
         wait_idle();
      end
      end_run();
   end

endmodule

`default_nettype wire

// File: alut.f
+incdir+logic
logic/alut_pkg.sv
logic/alut_mem.sv
logic/alut_decode.sv
logic/alut_execute.sv
logic/alut_ager.sv
logic/alut_result.sv
logic/alut_top.sv
bench/alut_tb.sv

// File: bench/alut_vectors.txt
# op(0 frame, 1 sweep) dst_mac src_mac src_port age_limit, all hex
# expected: hit fwd_port flood filter (frame), sweep_count (sweep)
0 020000000022 020000000011 2 0 0 0 1 0 0
0 020000000011 020000000022 1 0 1 2 0 0 0
0 020000000011 020000000033 2 0 1 2 0 1 0
0 020000000022 020000001100 3 0 1 1 0 0 0
0 020000000011 020000000044 0 0 0 0 1 0 0
0 020000001100 020000000055 1 0 1 3 0 0 0
# six frames seen, stamps 1 and 2 are older than 3
1 000000000000 000000000000 0 3 0 0 0 0 2
0 020000000022 020000000044 0 0 0 0 1 0 0
0 020000000033 020000000055 1 0 0 0 1 0 0
0 020000001100 020000000044 0 0 1 3 0 0 0
0 020000000055 020000001100 3 0 1 1 0 0 0
# same index for dst and src, lookup sees the old word
0 020000000066 020000000066 2 0 0 0 1 0 0
0 020000000066 020000000044 0 0 1 2 0 0 0
0 020000000066 020000006600 1 0 1 2 0 0 0
0 020000006600 020000000044 0 0 1 1 0 0 0
0 020000000066 020000000044 0 0 0 0 1 0 0
# fifteen frames seen, limit 5 drops stamps 7 and 9
1 000000000000 000000000000 0 5 0 0 0 0 2
0 020000000055 020000000044 0 0 0 0 1 0 0
0 020000006600 020000000011 2 0 1 1 0 0 0
